// File: lane_checker.sv
`timescale 1ns/100ps

module lane_checker (
   input  logic                        clock_async,
   input  logic                        reset,
   input  logic                        clear_counts,
   input  link_test_pkg::frame_t       rx_frame,
   output link_test_pkg::lane_status_t status
);

   logic start_detect;
   logic bonding_detect;
   logic waiting_for_start;
   logic waiting_for_bonding;
   logic ready;

   link_test_pkg::frame_t                  rx_d;
   logic                                   restart_sequence; // rx_d holds the marker
   logic                                   bonding_d;        // rx_d holds the bonding frame
   logic                                   prbs_restart;
   logic [link_test_pkg::payload_bits-1:0] prbs_word;
   logic [link_test_pkg::frame_bits-1:0]   expected;
   logic                                   link_error;

   logic [link_test_pkg::err_count_bits-1:0]  error_count;
   logic [link_test_pkg::good_count_bits-1:0] good_count;
   logic                                      cnt_maxed;

   // --------------------
   // framing detection
   // --------------------

   assign start_detect = (rx_frame.word.raw == link_test_pkg::start_word) &&
                         (rx_frame.charisk == link_test_pkg::start_k);

   assign bonding_detect = (rx_frame.word.raw == link_test_pkg::bonding_word) &&
                           (rx_frame.charisk == link_test_pkg::bonding_k);

   // held at seed until a marker and again through each marker
   assign prbs_restart = waiting_for_start | start_detect;

   prbs_gen i_prbs (
      .clock_async (clock_async),
      .reset       (reset),
      .restart     (prbs_restart),
      .err_pulse   (1'b0),
      .word        (prbs_word),
      .start       ()
   );

   // generator lags the input by one cycle so rx_d is compared
   assign expected = {prbs_word, link_test_pkg::comma_word};

   always_ff @(posedge clock_async) begin
      rx_d <= rx_frame;
   end

   always_ff @(posedge clock_async) begin
      if (reset) begin
         waiting_for_start   <= 1'b1;
         waiting_for_bonding <= 1'b1;
         ready               <= 1'b0;
         restart_sequence    <= 1'b0;
         bonding_d           <= 1'b0;
         link_error          <= 1'b0;
      end else begin
         if (start_detect)
            waiting_for_start <= 1'b0;
         if (bonding_detect && !waiting_for_start)
            waiting_for_bonding <= 1'b0;

         // needs a full marker + bonding pass before this one
         if (bonding_detect)
            ready <= ~(waiting_for_start | waiting_for_bonding);

         restart_sequence <= start_detect;
         bonding_d        <= bonding_detect;
         link_error       <= ready && !restart_sequence && !bonding_d &&
                             (rx_d.word.raw != expected);
      end
   end

   // --------------------
   // saturating counters
   // --------------------

   assign cnt_maxed = (&error_count) | (&good_count);

   always_ff @(posedge clock_async) begin
      if (reset || clear_counts || !ready) begin
         error_count <= '0;
         good_count  <= '0;
      end else if (!cnt_maxed) begin
         if (link_error)
            error_count <= error_count + 1'b1;
         else
            good_count <= good_count + 1'b1;
      end
   end

   assign status.ready       = ready;
   assign status.error_count = error_count;
   assign status.good_count  = good_count;

endmodule

// File: link_test_pkg.sv
package link_test_pkg;

   // -------------------
   // frame geometry
   localparam int frame_bits   = 64;
   localparam int payload_bits = 48;
   localparam int k_bits       = 8; // one K flag per byte

   // -------------------
   // link words
   localparam logic [15:0]           comma_word   = 16'h50bc;
   localparam logic [frame_bits-1:0] start_word   = {8{8'hfc}};
   localparam logic [frame_bits-1:0] bonding_word = {8'hdc, 8'hfb, 8'hfe, 8'h1c, 32'h9999_9999};
   localparam logic [k_bits-1:0]     start_k      = 8'hff;
   localparam logic [k_bits-1:0]     bonding_k    = 8'hf0; // upper four bytes are K
   localparam logic [k_bits-1:0]     payload_k    = 8'h01; // comma byte only

   // -------------------
   // sequencing
   localparam int restart_period = 100; // wraps after 101 frames
   localparam int period_bits    = $clog2(restart_period + 1);
   localparam logic [period_bits-1:0] last_index    = period_bits'(restart_period);
   localparam logic [period_bits-1:0] bonding_index = period_bits'(1);

   localparam logic [payload_bits-1:0] prbs_seed = payload_bits'(1);

   // counter widths
   localparam int err_count_bits  = 32;
   localparam int good_count_bits = 42;

   // payload word sits above the comma
   typedef struct packed {
      logic [payload_bits-1:0] payload;
      logic [15:0]             comma;
   } payload_view_t;

   typedef union packed {
      logic [frame_bits-1:0] raw;
      payload_view_t         pl;
   } frame_word_u;

   typedef struct packed {
      frame_word_u       word;
      logic [k_bits-1:0] charisk;
   } frame_t;

   typedef struct packed {
      logic                       ready;
      logic [err_count_bits-1:0]  error_count;
      logic [good_count_bits-1:0] good_count;
   } lane_status_t;

endpackage

// File: link_tester_checker.sv
`timescale 1ns/100ps

module link_tester_checker (
   input logic                        clock_async,
   input logic                        reset,
   input logic                        err_pulse,
   input logic                        clear_counts,
   input link_test_pkg::lane_status_t status0,
   input link_test_pkg::lane_status_t status1
);

   // ---------------------
   a_pulse_single: assert property (@(posedge clock_async) disable iff (reset)
      err_pulse |=> !err_pulse) else $error("err_pulse longer than one cycle");

   a_idle_zero0: assert property (@(posedge clock_async) disable iff (reset)
      !status0.ready |-> (status0.error_count == 0 && status0.good_count == 0))
      else $error("lane 0 counts nonzero while not ready");

   a_idle_zero1: assert property (@(posedge clock_async) disable iff (reset)
      !status1.ready |-> (status1.error_count == 0 && status1.good_count == 0))
      else $error("lane 1 counts nonzero while not ready");

   // counts only drop after a clear or a loss of ready
   a_no_drop0: assert property (@(posedge clock_async) disable iff (reset)
      ($past(!clear_counts) && $past(status0.ready)) |->
      (status0.error_count >= $past(status0.error_count) &&
       status0.good_count >= $past(status0.good_count)))
      else $error("lane 0 counter decreased");

   a_no_drop1: assert property (@(posedge clock_async) disable iff (reset)
      ($past(!clear_counts) && $past(status1.ready)) |->
      (status1.error_count >= $past(status1.error_count) &&
       status1.good_count >= $past(status1.good_count)))
      else $error("lane 1 counter decreased");

endmodule

bind prbs_link_tester link_tester_checker i_checker (
   .clock_async  (clock_async),
   .reset        (reset),
   .err_pulse    (err_pulse),
   .clear_counts (clear_counts),
   .status0      (status0),
   .status1      (status1)
);

// File: prbs_gen.sv
`timescale 1ns/100ps

module prbs_gen (
   input  logic                                 clock_async,
   input  logic                                 reset,
   input  logic                                 restart,
   input  logic                                 err_pulse,
   output logic [link_test_pkg::payload_bits-1:0] word,
   output logic                                 start
);

   logic [link_test_pkg::payload_bits-1:0] state;
   logic                                   in_restart; // seed loaded but word 0 not shown yet
   logic                                   feedback;

   // x^48 + x^47 + x^21 + x^20 + 1
   assign feedback = state[47] ^ state[46] ^ state[20] ^ state[19];

   always_ff @(posedge clock_async) begin
      if (reset || restart) begin
         state      <= link_test_pkg::prbs_seed;
         in_restart <= 1'b1;
      end else begin
         state      <= {state[46:0], feedback}; // one step per clock
         in_restart <= 1'b0;
      end
   end

   // first cycle out of restart shows the seed
   assign start = in_restart & ~restart;

   // injected error flips bit 0 of this word only and leaves the state alone
   assign word = state ^ {{(link_test_pkg::payload_bits - 1){1'b0}}, err_pulse};

endmodule

// File: prbs_link_tester.sv
`timescale 1ns/100ps

module prbs_link_tester (
   input  logic                        clock_async,
   input  logic                        reset,
   input  logic                        inj_err,
   input  logic                        cnt_clear,
   output link_test_pkg::frame_t       tx_frame0,
   output link_test_pkg::frame_t       tx_frame1,
   input  link_test_pkg::frame_t       rx_frame0,
   input  link_test_pkg::frame_t       rx_frame1,
   output link_test_pkg::lane_status_t status0,
   output link_test_pkg::lane_status_t status1
);

   logic                  err_pulse;
   logic                  clear_counts;
   link_test_pkg::frame_t tx_frame;

   tester_controls i_controls (
      .clock_async  (clock_async),
      .reset        (reset),
      .inj_err      (inj_err),
      .cnt_clear    (cnt_clear),
      .err_pulse    (err_pulse),
      .clear_counts (clear_counts)
   );

   tx_framer i_framer (
      .clock_async (clock_async),
      .reset       (reset),
      .err_pulse   (err_pulse),
      .frame       (tx_frame)
   );

   // same frame on both links
   assign tx_frame0 = tx_frame;
   assign tx_frame1 = tx_frame;

   // --------------------
   // receive lanes
   // --------------------

   lane_checker i_lane0 (
      .clock_async  (clock_async),
      .reset        (reset),
      .clear_counts (clear_counts),
      .rx_frame     (rx_frame0),
      .status       (status0)
   );

   lane_checker i_lane1 (
      .clock_async  (clock_async),
      .reset        (reset),
      .clear_counts (clear_counts),
      .rx_frame     (rx_frame1),
      .status       (status1)
   );

endmodule

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, then search the log for the fail message
verilator --binary --timing --assert --top-module tb_prbs_link_tester \
   -f vlog.f -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 || echo "Finished with errors" >> sim.log
grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; } || { echo "simulation passed"; exit 0; }

// File: tb_prbs_link_tester.sv
`timescale 1ns/100ps

module tb_prbs_link_tester;

   localparam int clk_period   = 8;
   localparam int period_len   = link_test_pkg::restart_period + 1;
   localparam int test_periods = 12; // 2+3+2+1+1+3 periods over the six tests
   localparam int settle_len   = 10;

   logic                        clock_async;
   logic                        reset;
   logic                        inj_err;
   logic                        cnt_clear;
   link_test_pkg::frame_t       tx_frame0;
   link_test_pkg::frame_t       tx_frame1;
   link_test_pkg::frame_t       rx_frame0;
   link_test_pkg::frame_t       rx_frame1;
   link_test_pkg::lane_status_t status0;
   link_test_pkg::lane_status_t status1;

   logic [link_test_pkg::payload_bits-1:0] ref_words [0:period_len-1];
   logic [31:0] rng_state;
   int          errors;
   int          tests_run;
   int          test_start_errors;
   int          lb_idx; // loopback view of the tx frame index
   logic        idle [2];
   logic        repair1; // feed lane 1 from the reference model
   int          corrupt_req [2];
   int          corrupt_used [2];
   logic [63:0] corrupt_mask [2];

   prbs_link_tester i_dut (.*);

   initial begin
      clock_async = 1'b0;
      forever #(clk_period / 2) clock_async = ~clock_async;
   end

   // ---------------------
   // reference model
   function automatic logic [47:0] prbs_step(input logic [47:0] s);
      return {s[46:0], s[47] ^ s[46] ^ s[20] ^ s[19]};
   endfunction

   function automatic link_test_pkg::frame_t ref_frame(input int k);
      link_test_pkg::frame_t f;
      if (k == 0) begin
         f.word.raw = link_test_pkg::start_word;
         f.charisk  = link_test_pkg::start_k;
      end else if (k == 1) begin
         f.word.raw = link_test_pkg::bonding_word;
         f.charisk  = link_test_pkg::bonding_k;
      end else begin
         f.word.pl.payload = ref_words[k];
         f.word.pl.comma   = link_test_pkg::comma_word;
         f.charisk         = link_test_pkg::payload_k;
      end
      return f;
   endfunction

   function automatic logic is_marker(input link_test_pkg::frame_t f);
      return f.word.raw == link_test_pkg::start_word && f.charisk == link_test_pkg::start_k;
   endfunction

   function automatic logic is_payload(input link_test_pkg::frame_t f);
      return f.word.pl.comma == link_test_pkg::comma_word &&
             f.charisk == link_test_pkg::payload_k;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic link_test_pkg::lane_status_t make_status(input logic rdy,
         input logic [31:0] err, input logic [41:0] good);
      link_test_pkg::lane_status_t s;
      s.ready       = rdy;
      s.error_count = err;
      s.good_count  = good;
      return s;
   endfunction

   // ---------------------
   // loopback from tx to rx
   always @(posedge clock_async) begin
      link_test_pkg::frame_t src;
      if (is_marker(tx_frame0))
         lb_idx = 0;
      else if (lb_idx < period_len - 1)
         lb_idx = lb_idx + 1;
      for (int lane = 0; lane < 2; lane++) begin
         src = (lane == 0) ? tx_frame0 : tx_frame1;
         if (lane == 1 && repair1)
            src = ref_frame(lb_idx);
         if (corrupt_req[lane] != corrupt_used[lane] && is_payload(src)) begin
            src.word.raw = src.word.raw ^ corrupt_mask[lane]; // one frame only
            corrupt_used[lane] = corrupt_used[lane] + 1;
         end
         if (idle[lane])
            src = '0;
         if (lane == 0)
            rx_frame0 <= src;
         else
            rx_frame1 <= src;
      end
   end

   // ---------------------
   // checks and helpers
   task automatic report_error(input string msg);
      $display("ERR %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_frame(input string what, input link_test_pkg::frame_t got,
         input link_test_pkg::frame_t exp);
      if (got !== exp)
         report_error($sformatf("%s frame %h, expected %h", what, got, exp));
   endtask

   // exact_good low means good_count must be at least the expected value
   task automatic check_status(input string what, input link_test_pkg::lane_status_t got,
         input link_test_pkg::lane_status_t exp, input bit exact_good);
      if (got.ready !== exp.ready || got.error_count !== exp.error_count ||
          (exact_good && got.good_count !== exp.good_count) ||
          (!exact_good && !(got.good_count >= exp.good_count)))
         report_error($sformatf("%s ready %b err %0d good %0d, expected %b %0d %0d", what,
            got.ready, got.error_count, got.good_count,
            exp.ready, exp.error_count, exp.good_count));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clock_async);
   endtask

   task automatic apply_reset();
      @(posedge clock_async);
      reset <= 1'b1;
      repeat (8) @(posedge clock_async);
      reset <= 1'b0;
   endtask

   task automatic begin_test();
      test_start_errors = errors;
      tests_run++;
   endtask

   task automatic end_test(input string name);
      if (errors == test_start_errors)
         $display("test %s: ok", name);
      else
         $display("test %s: %0d errors", name, errors - test_start_errors);
   endtask

   // ---------------------
   // directed tests
   task automatic transmit_sequence();
      begin_test();
      @(negedge clock_async);
      while (!is_marker(tx_frame0))
         @(negedge clock_async);
      for (int k = 0; k < period_len; k++) begin
         check_frame($sformatf("tx0 k=%0d", k), tx_frame0, ref_frame(k));
         check_frame($sformatf("tx1 k=%0d", k), tx_frame1, ref_frame(k));
         @(negedge clock_async);
      end
      end_test("transmit sequence");
   endtask

   task automatic clean_loopback();
      begin_test();
      wait_cycles(3 * period_len);
      check_status("lane0", status0, make_status(1'b1, 0, 1), 1'b0);
      check_status("lane1", status1, make_status(1'b1, 0, 1), 1'b0);
      end_test("clean loopback");
   endtask

   task automatic error_injection();
      logic [31:0] before0;
      begin_test();
      @(negedge clock_async);
      repair1 = 1'b1;
      while (!is_marker(tx_frame0))
         @(negedge clock_async);
      wait_cycles(10 + next_rand() % 20); // lands well inside the payload frames
      before0 = status0.error_count;
      @(posedge clock_async);
      inj_err <= 1'b1;
      wait_cycles(4);
      @(posedge clock_async);
      inj_err <= 1'b0;
      wait_cycles(settle_len);
      check_status("lane0", status0, make_status(1'b1, before0 + 1, 1), 1'b0);
      check_status("lane1", status1, make_status(1'b1, 0, 1), 1'b0);
      repair1 = 1'b0;
      end_test("error injection");
   endtask

   task automatic receive_corruption();
      logic [31:0] before0;
      logic [31:0] before1;
      begin_test();
      @(negedge clock_async);
      before0 = status0.error_count;
      before1 = status1.error_count;
      corrupt_mask[1] = {next_rand(), next_rand()} | 64'h1;
      corrupt_req[1]  = corrupt_req[1] + 1;
      while (corrupt_used[1] != corrupt_req[1])
         @(negedge clock_async);
      wait_cycles(settle_len);
      check_status("lane0", status0, make_status(1'b1, before0, 1), 1'b0);
      check_status("lane1", status1, make_status(1'b1, before1 + 1, 1), 1'b0);
      end_test("receive corruption");
   endtask

   task automatic counter_clear();
      begin_test();
      @(posedge clock_async);
      cnt_clear <= 1'b1;
      wait_cycles(4);
      check_status("lane0 held", status0, make_status(1'b1, 0, 0), 1'b1);
      check_status("lane1 held", status1, make_status(1'b1, 0, 0), 1'b1);
      @(posedge clock_async);
      cnt_clear <= 1'b0;
      wait_cycles(period_len);
      check_status("lane0", status0, make_status(1'b1, 0, 1), 1'b0);
      check_status("lane1", status1, make_status(1'b1, 0, 1), 1'b0);
      end_test("counter clear");
   endtask

   task automatic missing_start();
      begin_test();
      @(negedge clock_async);
      idle[1] = 1'b1;
      apply_reset();
      wait_cycles(3 * period_len);
      check_status("lane0", status0, make_status(1'b1, 0, 1), 1'b0);
      check_status("lane1", status1, make_status(1'b0, 0, 0), 1'b1);
      idle[1] = 1'b0;
      end_test("missing start");
   endtask

   // ---------------------
   initial begin
      logic [47:0] s;
      reset     = 1'b1;
      inj_err   = 1'b0;
      cnt_clear = 1'b0;
      rx_frame0 = '0;
      rx_frame1 = '0;
      rng_state = 32'h5187_db6e;
      errors    = 0;
      tests_run = 0;
      lb_idx    = 0;
      repair1   = 1'b0;
      for (int lane = 0; lane < 2; lane++) begin
         idle[lane]         = 1'b0;
         corrupt_req[lane]  = 0;
         corrupt_used[lane] = 0;
         corrupt_mask[lane] = '0;
      end
      s = link_test_pkg::prbs_seed;
      for (int k = 0; k < period_len; k++) begin
         ref_words[k] = s; // word k of the period
         s = prbs_step(s);
      end
      repeat (8) @(posedge clock_async);
      reset <= 1'b0;
      transmit_sequence();
      clean_loopback();
      error_injection();
      receive_corruption();
      counter_clear();
      missing_start();
      $display("tests run %0d, errors %0d", tests_run, errors);
      if (errors == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

   initial begin
      #(test_periods * period_len * clk_period + 2000);
      $display("watchdog timeout, the tests did not finish in time");
      $display("Finished with errors");
      $finish;
   end

endmodule

// File: tester_controls.sv
`timescale 1ns/100ps

module tester_controls (
   input  logic clock_async,
   input  logic reset,
   input  logic inj_err,
   input  logic cnt_clear,
   output logic err_pulse,
   output logic clear_counts
);

   logic [1:0] inj_sr; // [0] newest sample

   // --------------------
   // edge pulse and clear
   // --------------------

   always_ff @(posedge clock_async) begin
      if (reset) begin
         inj_sr       <= 2'b00;
         err_pulse    <= 1'b0;
         clear_counts <= 1'b0;
      end else begin
         inj_sr       <= {inj_sr[0], inj_err};
         err_pulse    <= (inj_sr == 2'b01); // one clock per rising edge
         clear_counts <= cnt_clear;
      end
   end

endmodule

// File: tx_framer.sv
`timescale 1ns/100ps

module tx_framer (
   input  logic                  clock_async,
   input  logic                  reset,
   input  logic                  err_pulse,
   output link_test_pkg::frame_t frame
);

   logic [link_test_pkg::period_bits-1:0]  frame_index;
   logic                                   wrap;
   logic                                   prbs_restart;
   logic [link_test_pkg::payload_bits-1:0] prbs_word;
   logic                                   prbs_start;

   // --------------------
   // period counter
   // --------------------

   assign wrap = (frame_index == link_test_pkg::last_index);

   always_ff @(posedge clock_async) begin
      if (reset || wrap)
         frame_index <= '0;
      else
         frame_index <= frame_index + 1'b1;
   end

   // generator restarts one cycle ahead of frame 0
   assign prbs_restart = reset | wrap;

   prbs_gen i_prbs (
      .clock_async (clock_async),
      .reset       (reset),
      .restart     (prbs_restart),
      .err_pulse   (err_pulse),
      .word        (prbs_word),
      .start       (prbs_start)
   );

   // --------------------
   // frame mux
   // --------------------

   // marker, bonding frame, then payload for the rest of the period
   always_ff @(posedge clock_async) begin
      if (prbs_start) begin
         frame.word.raw <= link_test_pkg::start_word;
         frame.charisk  <= link_test_pkg::start_k;
      end else if (frame_index == link_test_pkg::bonding_index) begin
         frame.word.raw <= link_test_pkg::bonding_word;
         frame.charisk  <= link_test_pkg::bonding_k;
      end else begin
         frame.word.pl.payload <= prbs_word;
         frame.word.pl.comma   <= link_test_pkg::comma_word;
         frame.charisk         <= link_test_pkg::payload_k;
      end
   end

endmodule

// File: vlog.f
link_test_pkg.sv
prbs_gen.sv
tx_framer.sv
lane_checker.sv
tester_controls.sv
prbs_link_tester.sv
link_tester_checker.sv
tb_prbs_link_tester.sv
